/* design/sd_reg_pkg.sv */
package sd_reg_pkg;

    localparam int WB_ADDR_W = 3;
    localparam int WB_DATA_W = 32;
    localparam int DIVISOR_W = 8;

    // Word addresses
    localparam logic [WB_ADDR_W-1:0] REG_ARGUMENT      = 3'd0;
    localparam logic [WB_ADDR_W-1:0] REG_COMMAND       = 3'd1;
    localparam logic [WB_ADDR_W-1:0] REG_RESPONSE      = 3'd2;
    localparam logic [WB_ADDR_W-1:0] REG_INT_STATUS    = 3'd3;
    localparam logic [WB_ADDR_W-1:0] REG_INT_ENABLE    = 3'd4;
    localparam logic [WB_ADDR_W-1:0] REG_DIVISOR       = 3'd5;
    localparam logic [WB_ADDR_W-1:0] REG_PRESENT_STATE = 3'd6;
    localparam logic [WB_ADDR_W-1:0] REG_SOFT_RESET    = 3'd7;

    // Interrupt status and enable layout, bit 0 is command complete
    typedef struct packed {
        logic index_err;
        logic crc_err;
        logic resp_timeout;
        logic cmd_complete;
    } sd_int_status_t;

endpackage

/* design/sd_cmd_pkg.sv */
package sd_cmd_pkg;

    localparam int CMD_INDEX_W       = 6;
    localparam int CMD_FRAME_W       = 48;
    localparam int CRC7_W            = 7;
    localparam int RESP_TIMEOUT_CLKS = 64;

    // Codes 2 and 3 behave as short
    typedef enum logic [1:0] {
        RESP_NONE  = 2'd0,
        RESP_SHORT = 2'd1
    } sd_resp_type_e;

    typedef struct packed {
        logic [CMD_INDEX_W-1:0] index;
        logic [31:0]            argument;
        sd_resp_type_e          resp_type;
        logic                   crc_check;
        logic                   index_check;
    } sd_cmd_req_t;

    typedef struct packed {
        logic                   timeout;
        logic                   crc_bad;
        logic [CMD_INDEX_W-1:0] index;
        logic [31:0]            content;
    } sd_cmd_result_t;

    // One bit step of CRC7, x^7 + x^3 + 1
    function automatic logic [CRC7_W-1:0] crc7_next(
        input logic [CRC7_W-1:0] crc,
        input logic              din
    );
        logic fb;
        fb = crc[CRC7_W-1] ^ din;
        return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    endfunction

endpackage

/* design/sd_wb_regs.sv */
module sd_wb_regs
    import sd_reg_pkg::*, sd_cmd_pkg::*;
#(
    parameter logic [DIVISOR_W-1:0] DIVISOR_RESET = 8'd4
) (
    input  logic                 aclk_i,
    input  logic                 rst_n_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [WB_ADDR_W-1:0] wb_adr_i,
    input  logic [WB_DATA_W-1:0] wb_dat_i,
    output logic [WB_DATA_W-1:0] wb_dat_o,
    output logic                 wb_ack_o,
    input  logic                 cmd_busy_i,
    input  logic                 cmd_done_i,
    input  sd_int_status_t       cmd_flags_i,
    input  logic [31:0]          resp_word_i,
    output sd_cmd_req_t          cmd_req_o,
    output logic                 cmd_start_o,
    output logic [DIVISOR_W-1:0] divisor_o,
    output logic                 soft_rst_o,
    output logic                 interrupt_o
);

    localparam int INT_W      = $bits(sd_int_status_t);
    localparam int CMD_WORD_W = 12;

    logic                  access;
    logic                  wr_en;
    logic [INT_W-1:0]      status_clr;
    logic [INT_W-1:0]      status_set;
    logic [WB_DATA_W-1:0]  argument_q;
    logic [CMD_WORD_W-1:0] command_q;
    sd_int_status_t        int_en_q;
    sd_int_status_t        int_status_q;
    logic [DIVISOR_W-1:0]  divisor_q;
    logic [WB_DATA_W-1:0]  rd_data;

    // First cycle of a bus cycle, ack closes it
    assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_en  = access && wb_we_i;

    assign status_clr = (wr_en && wb_adr_i == REG_INT_STATUS) ? wb_dat_i[INT_W-1:0] : '0;
    assign status_set = cmd_done_i ? cmd_flags_i : '0;

    always_ff @(posedge aclk_i) begin
        if (!rst_n_i) begin
            wb_ack_o     <= 1'b0;
            cmd_start_o  <= 1'b0;
            soft_rst_o   <= 1'b0;
            int_en_q     <= '0;
            int_status_q <= '0;
            divisor_q    <= DIVISOR_RESET;
        end else begin
            wb_ack_o    <= access;
            cmd_start_o <= wr_en && (wb_adr_i == REG_COMMAND);
            soft_rst_o  <= wr_en && (wb_adr_i == REG_SOFT_RESET) && wb_dat_i[0];
            if (wr_en && wb_adr_i == REG_INT_ENABLE) begin
                int_en_q <= wb_dat_i[INT_W-1:0];
            end
            if (wr_en && wb_adr_i == REG_DIVISOR) begin
                divisor_q <= wb_dat_i[DIVISOR_W-1:0];
            end
            // Set wins over clear
            int_status_q <= (int_status_q & ~status_clr) | status_set;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (wr_en && wb_adr_i == REG_ARGUMENT) begin
            argument_q <= wb_dat_i;
        end
        if (wr_en && wb_adr_i == REG_COMMAND) begin
            command_q <= wb_dat_i[CMD_WORD_W-1:0];
        end
        if (access) begin
            wb_dat_o <= rd_data;
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            REG_ARGUMENT:      rd_data = argument_q;
            REG_COMMAND:       rd_data[CMD_WORD_W-1:0] = command_q;
            REG_RESPONSE:      rd_data = resp_word_i;
            REG_INT_STATUS:    rd_data[INT_W-1:0] = int_status_q;
            REG_INT_ENABLE:    rd_data[INT_W-1:0] = int_en_q;
            REG_DIVISOR:       rd_data[DIVISOR_W-1:0] = divisor_q;
            REG_PRESENT_STATE: rd_data[0] = cmd_busy_i;
            default:           rd_data = '0;
        endcase
    end

    // Command word fields
    assign cmd_req_o.index       = command_q[5:0];
    assign cmd_req_o.argument    = argument_q;
    assign cmd_req_o.resp_type   = sd_resp_type_e'(command_q[9:8]);
    assign cmd_req_o.crc_check   = command_q[10];
    assign cmd_req_o.index_check = command_q[11];

    assign divisor_o   = divisor_q;
    assign interrupt_o = |(int_status_q & int_en_q);

endmodule

/* design/sd_clock_divider.sv */
module sd_clock_divider
    import sd_reg_pkg::*;
(
    input  logic                 aclk_i,
    input  logic                 rst_n_i,
    input  logic [DIVISOR_W-1:0] divisor_i,
    output logic                 sd_clk_o,
    output logic                 sd_rise_o,
    output logic                 sd_fall_o
);

    logic [DIVISOR_W-1:0] count_q;
    logic                 phase_q;
    logic                 wrap;

    // Covers a divisor lowered below the running count
    assign wrap = (count_q >= divisor_i);

    always_ff @(posedge aclk_i) begin
        if (!rst_n_i) begin
            count_q   <= '0;
            phase_q   <= 1'b0;
            sd_clk_o  <= 1'b0;
            sd_rise_o <= 1'b0;
            sd_fall_o <= 1'b0;
        end else begin
            count_q   <= wrap ? '0 : count_q + 1'b1;
            // Strobe leads the clock edge by one cycle
            sd_rise_o <= wrap && !phase_q;
            sd_fall_o <= wrap && phase_q;
            if (wrap) begin
                phase_q <= !phase_q;
            end
            sd_clk_o <= phase_q;
        end
    end

endmodule

/* design/sd_cmd_master.sv */
module sd_cmd_master
    import sd_reg_pkg::*, sd_cmd_pkg::*;
(
    input  logic                   aclk_i,
    input  logic                   rst_n_i,
    input  logic                   soft_rst_i,
    input  sd_cmd_req_t            cmd_req_i,
    input  logic                   cmd_start_i,
    input  logic                   rx_done_i,
    input  sd_cmd_result_t         rx_result_i,
    output logic                   cmd_busy_o,
    output logic                   cmd_done_o,
    output sd_int_status_t         cmd_flags_o,
    output logic [31:0]            resp_word_o,
    output logic                   tx_start_o,
    output logic [CMD_INDEX_W-1:0] tx_index_o,
    output logic [31:0]            tx_argument_o,
    output logic                   expect_resp_o
);

    sd_cmd_req_t req_q;
    logic        accept;
    logic        finish;
    logic        resp_valid;

    // A start while inhibit is set is dropped
    assign accept     = cmd_start_i && !cmd_busy_o;
    assign finish     = rx_done_i && cmd_busy_o;
    assign resp_valid = expect_resp_o && !rx_result_i.timeout;

    always_ff @(posedge aclk_i) begin
        if (!rst_n_i || soft_rst_i) begin
            cmd_busy_o <= 1'b0;
            tx_start_o <= 1'b0;
            cmd_done_o <= 1'b0;
        end else begin
            tx_start_o <= accept;
            cmd_done_o <= finish;
            if (accept) begin
                cmd_busy_o <= 1'b1;
            end else if (finish) begin
                cmd_busy_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk_i) begin
        if (accept) begin
            req_q <= cmd_req_i;
        end
        if (finish) begin
            cmd_flags_o.cmd_complete <= 1'b1;
            cmd_flags_o.resp_timeout <= rx_result_i.timeout;
            cmd_flags_o.crc_err      <= resp_valid && req_q.crc_check && rx_result_i.crc_bad;
            cmd_flags_o.index_err    <= resp_valid && req_q.index_check &&
                                        (rx_result_i.index != req_q.index);
        end
    end

    // Response register reads 0 until a response arrives
    always_ff @(posedge aclk_i) begin
        if (!rst_n_i) begin
            resp_word_o <= '0;
        end else if (finish && resp_valid) begin
            resp_word_o <= rx_result_i.content;
        end
    end

    assign tx_index_o    = req_q.index;
    assign tx_argument_o = req_q.argument;
    assign expect_resp_o = (req_q.resp_type != RESP_NONE);

endmodule

/* design/sd_cmd_serial_host.sv */
module sd_cmd_serial_host
    import sd_cmd_pkg::*;
(
    input  logic                   aclk_i,
    input  logic                   rst_n_i,
    input  logic                   soft_rst_i,
    input  logic                   sd_rise_i,
    input  logic                   sd_fall_i,
    input  logic                   tx_start_i,
    input  logic [CMD_INDEX_W-1:0] tx_index_i,
    input  logic [31:0]            tx_argument_i,
    input  logic                   expect_resp_i,
    input  logic                   sd_cmd_i,
    output logic                   sd_cmd_o,
    output logic                   sd_cmd_oe_o,
    output logic                   rx_done_o,
    output sd_cmd_result_t         rx_result_o
);

    // Bits covered by the CRC, start through argument
    localparam int CRC_BITS = CMD_FRAME_W - CRC7_W - 1;
    localparam int CNT_W    = $clog2(CMD_FRAME_W + RESP_TIMEOUT_CLKS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TX,
        ST_WAIT,
        ST_RX
    } state_e;

    state_e                 state_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [CMD_FRAME_W-1:0] shift_q;
    logic [CMD_FRAME_W-1:0] rx_next;
    logic [CRC_BITS-1:0]    tx_head;
    logic [CRC7_W-1:0]      tx_crc;
    logic [CRC7_W-1:0]      crc_q;

    always_comb begin
        tx_head = {2'b01, tx_index_i, tx_argument_i};
        tx_crc  = '0;
        for (int i = CRC_BITS - 1; i >= 0; i--) begin
            tx_crc = crc7_next(tx_crc, tx_head[i]);
        end
    end

    assign rx_next = {shift_q[CMD_FRAME_W-2:0], sd_cmd_i};

    always_ff @(posedge aclk_i) begin
        if (!rst_n_i || soft_rst_i) begin
            state_q     <= ST_IDLE;
            cnt_q       <= '0;
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
            rx_done_o   <= 1'b0;
        end else begin
            rx_done_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (tx_start_i) begin
                        shift_q <= {tx_head, tx_crc, 1'b1};
                        cnt_q   <= '0;
                        state_q <= ST_TX;
                    end
                end
                ST_TX: begin
                    if (sd_fall_i && cnt_q == CNT_W'(CMD_FRAME_W)) begin
                        // End bit period over, release the line
                        sd_cmd_o    <= 1'b1;
                        sd_cmd_oe_o <= 1'b0;
                        cnt_q       <= '0;
                        if (expect_resp_i) begin
                            state_q <= ST_WAIT;
                        end else begin
                            rx_result_o <= '0;
                            rx_done_o   <= 1'b1;
                            state_q     <= ST_IDLE;
                        end
                    end else if (sd_fall_i) begin
                        sd_cmd_o    <= shift_q[CMD_FRAME_W-1];
                        sd_cmd_oe_o <= 1'b1;
                        shift_q     <= shift_q << 1;
                        cnt_q       <= cnt_q + 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (sd_rise_i && !sd_cmd_i) begin
                        // Start bit, adds nothing to the CRC
                        shift_q <= '0;
                        crc_q   <= '0;
                        cnt_q   <= CNT_W'(1);
                        state_q <= ST_RX;
                    end else if (sd_rise_i && cnt_q == CNT_W'(RESP_TIMEOUT_CLKS - 1)) begin
                        rx_result_o <= '{timeout: 1'b1, crc_bad: 1'b0, index: '0, content: '0};
                        rx_done_o   <= 1'b1;
                        state_q     <= ST_IDLE;
                    end else if (sd_rise_i) begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_RX: begin
                    if (sd_rise_i) begin
                        shift_q <= rx_next;
                        cnt_q   <= cnt_q + 1'b1;
                        if (cnt_q < CNT_W'(CRC_BITS)) begin
                            crc_q <= crc7_next(crc_q, sd_cmd_i);
                        end
                        if (cnt_q == CNT_W'(CMD_FRAME_W - 1)) begin
                            rx_result_o.timeout <= 1'b0;
                            rx_result_o.crc_bad <= (rx_next[1 +: CRC7_W] != crc_q);
                            rx_result_o.index   <= rx_next[CMD_FRAME_W-3 -: CMD_INDEX_W];
                            rx_result_o.content <= rx_next[CRC7_W+1 +: 32];
                            rx_done_o           <= 1'b1;
                            state_q             <= ST_IDLE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

/* design/sd_emmc_controller.sv */
module sd_emmc_controller
    import sd_reg_pkg::*, sd_cmd_pkg::*;
#(
    parameter logic [DIVISOR_W-1:0] DIVISOR_RESET = 8'd4
) (
    input  logic                 aclk_i,
    input  logic                 rst_n_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [WB_ADDR_W-1:0] wb_adr_i,
    input  logic [WB_DATA_W-1:0] wb_dat_i,
    output logic [WB_DATA_W-1:0] wb_dat_o,
    output logic                 wb_ack_o,
    output logic                 sd_clk_o,
    output logic                 sd_cmd_o,
    output logic                 sd_cmd_oe_o,
    input  logic                 sd_cmd_i,
    output logic                 interrupt_o
);

    sd_cmd_req_t            cmd_req;
    logic                   cmd_start;
    logic                   cmd_busy;
    logic                   cmd_done;
    sd_int_status_t         cmd_flags;
    logic [31:0]            resp_word;
    logic [DIVISOR_W-1:0]   divisor;
    logic                   soft_rst;
    logic                   sd_rise;
    logic                   sd_fall;
    logic                   tx_start;
    logic [CMD_INDEX_W-1:0] tx_index;
    logic [31:0]            tx_argument;
    logic                   expect_resp;
    logic                   rx_done;
    sd_cmd_result_t         rx_result;

    sd_wb_regs #(
        .DIVISOR_RESET(DIVISOR_RESET)
    ) u_wb_regs (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .cmd_busy_i(cmd_busy), .cmd_done_i(cmd_done),
        .cmd_flags_i(cmd_flags), .resp_word_i(resp_word),
        .cmd_req_o(cmd_req), .cmd_start_o(cmd_start),
        .divisor_o(divisor), .soft_rst_o(soft_rst),
        .interrupt_o(interrupt_o)
    );

    sd_clock_divider u_clock_divider (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .divisor_i(divisor),
        .sd_clk_o(sd_clk_o), .sd_rise_o(sd_rise), .sd_fall_o(sd_fall)
    );

    sd_cmd_master u_cmd_master (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .soft_rst_i(soft_rst),
        .cmd_req_i(cmd_req), .cmd_start_i(cmd_start),
        .rx_done_i(rx_done), .rx_result_i(rx_result),
        .cmd_busy_o(cmd_busy), .cmd_done_o(cmd_done),
        .cmd_flags_o(cmd_flags), .resp_word_o(resp_word),
        .tx_start_o(tx_start), .tx_index_o(tx_index),
        .tx_argument_o(tx_argument), .expect_resp_o(expect_resp)
    );

    sd_cmd_serial_host u_cmd_serial_host (
        .aclk_i(aclk_i), .rst_n_i(rst_n_i), .soft_rst_i(soft_rst),
        .sd_rise_i(sd_rise), .sd_fall_i(sd_fall),
        .tx_start_i(tx_start), .tx_index_i(tx_index),
        .tx_argument_i(tx_argument), .expect_resp_i(expect_resp),
        .sd_cmd_i(sd_cmd_i), .sd_cmd_o(sd_cmd_o), .sd_cmd_oe_o(sd_cmd_oe_o),
        .rx_done_o(rx_done), .rx_result_o(rx_result)
    );

endmodule

/* verif/sd_emmc_controller_sva.sv */
module sd_emmc_controller_sva (
    input logic aclk_i,
    input logic rst_n_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i,
    input logic cmd_busy_i,
    input logic sd_cmd_oe_i
);
    timeunit 1ns;
    timeprecision 1ps;

    ack_single_cycle: assert property (
        @(posedge aclk_i) disable iff (!rst_n_i)
        wb_ack_i |=> !wb_ack_i
    ) else $error("wb_ack_o stayed high for more than one cycle");

    // Ack only answers a strobe seen one cycle earlier
    ack_after_strobe: assert property (
        @(posedge aclk_i) disable iff (!rst_n_i)
        wb_ack_i |-> $past(wb_cyc_i && wb_stb_i)
    ) else $error("wb_ack_o without a strobe in the previous cycle");

    oe_only_when_busy: assert property (
        @(posedge aclk_i) disable iff (!rst_n_i)
        $rose(sd_cmd_oe_i) |-> cmd_busy_i
    ) else $error("sd_cmd_oe_o rose while the command path was idle");

endmodule

bind sd_emmc_controller sd_emmc_controller_sva u_sva (
    .aclk_i(aclk_i),
    .rst_n_i(rst_n_i),
    .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i),
    .wb_ack_i(wb_ack_o),
    .cmd_busy_i(cmd_busy),
    .sd_cmd_oe_i(sd_cmd_oe_o)
);

/* verif/sd_emmc_controller_tb.sv */
module sd_emmc_controller_tb
    import sd_reg_pkg::*, sd_cmd_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [DIVISOR_W-1:0] DIV_RESET = 8'd4;
    localparam int NUM_CMDS       = 20;
    localparam int MAX_DIV        = 3;
    // Longest command in system clocks, timeout case plus margin
    localparam int CMD_CLKS       = 140 * 2 * (MAX_DIV + 1);
    localparam int WATCHDOG_NS    = (NUM_CMDS + 3) * (CMD_CLKS + 100) * 20 * 2;
    localparam int MODE_PROPER    = 0;
    localparam int MODE_SILENT    = 1;
    localparam int MODE_BAD_CRC   = 2;
    localparam int MODE_BAD_INDEX = 3;

    logic                 aclk = 1'b0;
    logic                 rst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic [WB_DATA_W-1:0] wb_dat_r;
    logic                 wb_ack;
    logic                 sd_clk;
    logic                 sd_cmd_out;
    logic                 sd_cmd_oe;
    logic                 sd_cmd_in;
    logic                 irq;

    logic [31:0]    rng_state = 32'd50;
    string          test_name = "";
    int             card_mode;
    int             card_delay;
    logic [31:0]    card_content;
    logic [5:0]     exp_index;
    logic [31:0]    exp_arg;
    logic [31:0]    exp_resp = 32'd0;
    sd_int_status_t exp_status;
    int             exp_frames = 0;
    int             frame_count = 0;

    sd_emmc_controller #(
        .DIVISOR_RESET(DIV_RESET)
    ) DUT (
        .aclk_i(aclk), .rst_n_i(rst_n),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
        .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
        .sd_clk_o(sd_clk), .sd_cmd_o(sd_cmd_out), .sd_cmd_oe_o(sd_cmd_oe),
        .sd_cmd_i(sd_cmd_in), .interrupt_o(irq)
    );

    always #10 aclk = ~aclk;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = crc[6] ^ bits[i];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    function automatic sd_int_status_t expected_status(input int mode, input logic expect_resp,
                                                       input logic crc_chk, input logic idx_chk);
        sd_int_status_t s;
        s = '0;
        s.cmd_complete = 1'b1;
        if (expect_resp) begin
            s.resp_timeout = (mode == MODE_SILENT);
            s.crc_err      = crc_chk && (mode == MODE_BAD_CRC);
            s.index_err    = idx_chk && (mode == MODE_BAD_INDEX);
        end
        return s;
    endfunction

    task automatic stop_on_failure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s, %s: expected %08h, actual %08h", test_name, what, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_status(input string what, input sd_int_status_t expected,
                                input sd_int_status_t actual);
        if (actual !== expected) begin
            $display("FAIL %s, %s: expected %04b, actual %04b", test_name, what, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic bus_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(negedge aclk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        do begin
            @(negedge aclk);
            waited++;
            if (waited > 4) begin
                $display("No Wishbone ack for an access to register %0d", adr);
                stop_on_failure();
            end
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input logic [WB_ADDR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic read_and_check(input logic [WB_ADDR_W-1:0] adr, input logic [31:0] expected,
                                  input string what);
        logic [31:0] rdata;
        bus_access(1'b0, adr, 32'd0, rdata);
        check_word(what, expected, rdata);
    endtask

    task automatic wait_cycles_for(input string what, ref logic sig);
        int waited;
        waited = 0;
        while (!sig) begin
            @(negedge aclk);
            waited++;
            if (waited > CMD_CLKS) begin
                $display("Gave up waiting for %s in test %s", what, test_name);
                stop_on_failure();
            end
        end
    endtask

    // Card clock half period is divisor + 1 system clocks
    task automatic check_card_clock(input int divisor);
        int   half;
        int   waited;
        logic level;
        waited = 0;
        half   = 0;
        // The first half period after a divisor write can be short
        for (int edge_n = 0; edge_n < 2; edge_n++) begin
            level = sd_clk;
            half  = 0;
            while (sd_clk == level) begin
                @(negedge aclk);
                half++;
                waited++;
                if (waited > CMD_CLKS) begin
                    $display("The card clock stopped toggling in test %s", test_name);
                    stop_on_failure();
                end
            end
        end
        check_word("card clock half period", 32'(divisor + 1), 32'(half));
    endtask

    task automatic start_command(input int mode, input logic [5:0] index, input logic [31:0] arg,
                                 input logic [1:0] rtype, input logic crc_chk,
                                 input logic idx_chk);
        logic expect_resp;
        expect_resp  = (rtype != 2'd0);
        card_mode    = expect_resp ? mode : MODE_SILENT;
        card_delay   = 2 + int'(next_random() % 19);
        card_content = next_random();
        exp_index    = index;
        exp_arg      = arg;
        exp_status   = expected_status(card_mode, expect_resp, crc_chk, idx_chk);
        if (expect_resp && card_mode != MODE_SILENT) begin
            exp_resp = card_content;
        end
        exp_frames++;
        write_reg(REG_ARGUMENT, arg);
        write_reg(REG_COMMAND, {20'd0, idx_chk, crc_chk, rtype, 2'b00, index});
    endtask

    task automatic finish_command();
        logic [31:0] rdata;
        wait_cycles_for("interrupt", irq);
        bus_access(1'b0, REG_INT_STATUS, 32'd0, rdata);
        check_status("interrupt status", exp_status, sd_int_status_t'(rdata[3:0]));
        read_and_check(REG_RESPONSE, exp_resp, "response");
        read_and_check(REG_PRESENT_STATE, 32'd0, "inhibit after completion");
        check_word("frames seen by card", exp_frames, frame_count);
        write_reg(REG_INT_STATUS, 32'hF);
        check_word("interrupt after clear", 32'd0, 32'(irq));
        read_and_check(REG_INT_STATUS, 32'd0, "status after clear");
    endtask

    task automatic check_frame(input logic [47:0] frame);
        check_word("frame start bit", 32'd0, 32'(frame[47]));
        check_word("frame transmit bit", 32'd1, 32'(frame[46]));
        check_word("frame index", 32'(exp_index), 32'(frame[45:40]));
        check_word("frame argument", exp_arg, frame[39:8]);
        check_word("frame CRC7", 32'(crc7_of(frame[47:8])), 32'(frame[7:1]));
        check_word("frame end bit", 32'd1, 32'(frame[0]));
    endtask

    // Card: samples on rising card clock, answers on falling card clock
    initial begin : card_model
        logic        clk_prev;
        logic        resp_active;
        logic [47:0] rx_frame;
        logic [47:0] resp_frame;
        logic [39:0] resp_head;
        logic [5:0]  index_flip;
        logic [6:0]  crc_flip;
        int          rx_bits;
        int          resp_wait;
        int          resp_bit;
        sd_cmd_in   = 1'b1;
        clk_prev    = 1'b0;
        resp_active = 1'b0;
        rx_bits     = 0;
        resp_wait   = 0;
        resp_bit    = 0;
        forever begin
            @(negedge aclk);
            if (sd_clk && !clk_prev) begin
                if (sd_cmd_oe) begin
                    rx_frame = {rx_frame[46:0], sd_cmd_out};
                    rx_bits++;
                    if (rx_bits == CMD_FRAME_W) begin
                        check_frame(rx_frame);
                        frame_count++;
                        rx_bits = 0;
                        if (card_mode != MODE_SILENT) begin
                            index_flip = (card_mode == MODE_BAD_INDEX) ? 6'h15 : 6'h00;
                            crc_flip   = (card_mode == MODE_BAD_CRC) ? 7'h04 : 7'h00;
                            resp_head  = {2'b00, rx_frame[45:40] ^ index_flip, card_content};
                            resp_frame = {resp_head, crc7_of(resp_head) ^ crc_flip, 1'b1};
                            resp_active = 1'b1;
                            resp_wait   = card_delay;
                            resp_bit    = 0;
                        end
                    end
                end else begin
                    // Partial frame is dropped
                    rx_bits = 0;
                end
            end
            if (!sd_clk && clk_prev && resp_active) begin
                if (resp_wait > 0) begin
                    resp_wait--;
                end else if (resp_bit < CMD_FRAME_W) begin
                    sd_cmd_in = resp_frame[CMD_FRAME_W - 1 - resp_bit];
                    resp_bit++;
                end else begin
                    sd_cmd_in   = 1'b1;
                    resp_active = 1'b0;
                end
            end
            clk_prev = sd_clk;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        stop_on_failure();
    end

    initial begin : main
        logic [31:0] rnd;
        logic [1:0]  rtype;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (8) @(posedge aclk);
        @(negedge aclk);

        test_name = "reset values";
        check_word("wb_ack_o", 32'd0, 32'(wb_ack));
        check_word("interrupt_o", 32'd0, 32'(irq));
        check_word("sd_clk_o", 32'd0, 32'(sd_clk));
        check_word("sd_cmd_o", 32'd1, 32'(sd_cmd_out));
        check_word("sd_cmd_oe_o", 32'd0, 32'(sd_cmd_oe));
        rst_n = 1'b1;
        read_and_check(REG_RESPONSE, 32'd0, "response");
        read_and_check(REG_INT_STATUS, 32'd0, "interrupt status");
        read_and_check(REG_INT_ENABLE, 32'd0, "interrupt enable");
        read_and_check(REG_PRESENT_STATE, 32'd0, "present state");
        read_and_check(REG_DIVISOR, 32'(DIV_RESET), "divisor");

        test_name = "register read-back";
        for (int n = 0; n < 4; n++) begin
            rnd = next_random();
            write_reg(REG_ARGUMENT, rnd);
            read_and_check(REG_ARGUMENT, rnd, "argument");
            rnd = next_random();
            write_reg(REG_INT_ENABLE, rnd);
            read_and_check(REG_INT_ENABLE, {28'd0, rnd[3:0]}, "interrupt enable");
            rnd = next_random();
            write_reg(REG_DIVISOR, rnd);
            read_and_check(REG_DIVISOR, {24'd0, rnd[7:0]}, "divisor");
        end

        test_name = "random commands";
        for (int n = 0; n < NUM_CMDS; n++) begin
            rnd = next_random();
            write_reg(REG_DIVISOR, rnd % (MAX_DIV + 1));
            check_card_clock(int'(rnd % (MAX_DIV + 1)));
            write_reg(REG_INT_ENABLE, {28'd0, rnd[11:8] | 4'h1});
            rtype = (n % 5 == 4) ? 2'd0 : ((rnd[17:16] == 2'd0) ? 2'd1 : rnd[17:16]);
            start_command(n % 4, rnd[29:24], next_random(), rtype, rnd[18], rnd[19]);
            finish_command();
        end

        test_name = "inhibit";
        write_reg(REG_INT_ENABLE, 32'hF);
        start_command(MODE_PROPER, 6'd17, next_random(), 2'd1, 1'b1, 1'b1);
        read_and_check(REG_PRESENT_STATE, 32'd1, "inhibit during command");
        // Index 42 with both checks, must be ignored
        write_reg(REG_COMMAND, 32'h0000_0D2A);
        finish_command();

        test_name = "soft reset";
        write_reg(REG_DIVISOR, 32'd1);
        start_command(MODE_SILENT, 6'd8, next_random(), 2'd1, 1'b0, 1'b0);
        wait_cycles_for("command line enable", sd_cmd_oe);
        repeat (20) @(negedge aclk);
        write_reg(REG_SOFT_RESET, 32'd1);
        read_and_check(REG_PRESENT_STATE, 32'd0, "inhibit after soft reset");
        check_word("line enable after soft reset", 32'd0, 32'(sd_cmd_oe));
        exp_frames = exp_frames - 1;
        repeat (200) @(negedge aclk);
        check_word("frames after soft reset", exp_frames, frame_count);
        read_and_check(REG_INT_STATUS, 32'd0, "status after soft reset");

        test_name = "command after soft reset";
        start_command(MODE_PROPER, 6'd55, next_random(), 2'd2, 1'b1, 1'b1);
        finish_command();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* project.f */
design/sd_reg_pkg.sv
design/sd_cmd_pkg.sv
design/sd_wb_regs.sv
design/sd_clock_divider.sv
design/sd_cmd_master.sv
design/sd_cmd_serial_host.sv
design/sd_emmc_controller.sv
verif/sd_emmc_controller_sva.sv
verif/sd_emmc_controller_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
    --top-module sd_emmc_controller_tb -Mdir obj_dir -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi
exit 0
